/* cmd_decoder.sv */
`timescale 1ns/1ps

module cmd_decoder
    import cmd_pkg::*;
    import dac_pkg::*;
#(
    parameter int NUM_DACS = 8
) (
    input  logic                      CLK100MHZ,
    input  logic                      reset,
    input  logic                      cmd_valid,
    input  cmd_op_t                   cmd_op,
    input  payload_u                  cmd_payload,
    input  logic [7:0]                cmd_len,
    input  logic [31:0]               pattern,
    input  logic                      ldac_busy,
    input  logic [NUM_DACS-1:0]       dac_busy,
    output logic                      reply_valid,
    output logic [31:0]               reply_data,
    output logic [2:0]                reply_len,
    output logic                      ldac_len_we,
    output logic                      pattern_we,
    output payload_u                  reg_payload,
    output logic                      ldac_start,
    output logic [NUM_DACS-1:0]       dac_start,
    output logic [DAC_WORD_WIDTH-1:0] dac_word
);

    // FSM states
    localparam logic [2:0] ST_IDLE     = 3'd0;
    localparam logic [2:0] ST_BUSY_ON  = 3'd1;
    localparam logic [2:0] ST_BUSY_OFF = 3'd2;
    localparam logic [2:0] ST_LDAC     = 3'd3;
    localparam logic [2:0] ST_UNKNOWN  = 3'd4;

    logic [2:0]          state;
    logic                accept;
    logic [NUM_DACS-1:0] chan_mask;
    logic                len_ok;

    // New command only when idle and no reply is on the way out
    // Anything else is dropped
    assign accept = cmd_valid && (state == ST_IDLE) && !reply_valid;

    // Mask trimmed or widened to the channel count
    assign chan_mask = NUM_DACS'(cmd_payload.dac.chan_mask);
    assign len_ok    = (cmd_len == WRITE_REG_BYTES);

    // Register writes land at the end of the command cycle
    assign ldac_len_we = accept && (cmd_op == OP_LDAC_LENGTH);
    assign pattern_we  = accept && (cmd_op == OP_UPDATE_BITS);
    assign reg_payload = cmd_payload;

    ////////////////////
    // Main FSM
    ////////////////////
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            state       <= ST_IDLE;
            reply_valid <= 1'b0;
            ldac_start  <= 1'b0;
            dac_start   <= '0;
        end else begin
            // One-cycle strobes by default
            reply_valid <= 1'b0;
            ldac_start  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        case (cmd_op)
                            OP_WRITE_REG: begin
                                if (!len_ok) begin
                                    // Error code then the length we got
                                    reply_valid <= 1'b1;
                                    reply_data  <= {REPLY_WRONG_LEN, cmd_len, 16'h0000};
                                    reply_len   <= 3'd2;
                                end else if (chan_mask != '0) begin
                                    dac_start <= chan_mask;
                                    dac_word  <= cmd_payload.dac.dac_word;
                                    state     <= ST_BUSY_ON;
                                end
                            end
                            OP_LD: begin
                                if (chan_mask != '0) begin
                                    dac_start <= chan_mask;
                                    dac_word  <= DAC_LD_WORD;
                                    state     <= ST_BUSY_ON;
                                end
                            end
                            OP_LDAC: begin
                                ldac_start <= 1'b1;
                                state      <= ST_LDAC;
                            end
                            OP_READ_BITS: begin
                                reply_valid <= 1'b1;
                                reply_data  <= pattern;
                                reply_len   <= 3'd4;
                            end
                            // Register commands handled by the write strobes
                            OP_LDAC_LENGTH, OP_UPDATE_BITS: begin
                                state <= ST_IDLE;
                            end
                            default: begin
                                reply_valid <= 1'b1;
                                reply_data  <= {REPLY_UNKNOWN, 24'h000000};
                                reply_len   <= 3'd1;
                                state       <= ST_UNKNOWN;
                            end
                        endcase
                    end
                end
                // Hold start until a channel has picked it up
                ST_BUSY_ON: begin
                    if (dac_busy != '0) begin
                        dac_start <= '0;
                        state     <= ST_BUSY_OFF;
                    end
                end
                // Frame done when every channel is idle again
                ST_BUSY_OFF: begin
                    if (dac_busy == '0) begin
                        state <= ST_IDLE;
                    end
                end
                // Start strobe still in flight on the first cycle here
                ST_LDAC: begin
                    if (!ldac_start && !ldac_busy) begin
                        state <= ST_IDLE;
                    end
                end
                // Reply cycle of an unknown opcode
                ST_UNKNOWN: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Replies are single strobes, never back to back
    a_reply_single: assert property (@(posedge CLK100MHZ) disable iff (reset)
        reply_valid |=> !reply_valid);

endmodule

/* cmd_pkg.sv */
package cmd_pkg;

    ////////////////////
    // Command opcodes
    ////////////////////
    // Any value not listed here gets the unknown reply
    typedef enum logic [7:0] {
        OP_WRITE_REG   = 8'h01,
        OP_LD          = 8'h02,
        OP_LDAC        = 8'h03,
        OP_LDAC_LENGTH = 8'h04,
        OP_UPDATE_BITS = 8'h05,
        OP_READ_BITS   = 8'h06
    } cmd_op_t;

    // One-byte error reply codes
    localparam logic [7:0] REPLY_WRONG_LEN = 8'hE1;
    localparam logic [7:0] REPLY_UNKNOWN   = 8'hEE;

    // Payload bytes required by a register write
    localparam logic [7:0] WRITE_REG_BYTES = 8'd4;

    ////////////////////
    // Payload views
    ////////////////////
    // DAC commands, mask and word sit in the low 32 bits
    typedef struct packed {
        logic [31:0] unused;
        logic [7:0]  chan_mask;
        logic [23:0] dac_word;
    } dac_view_t;

    // Pattern update, mask first then data
    typedef struct packed {
        logic [31:0] mask;
        logic [31:0] data;
    } pattern_view_t;

    // Same 64-bit word, read per opcode
    typedef union packed {
        dac_view_t     dac;
        pattern_view_t pat;
    } payload_u;

endpackage

/* ctrl_regs.sv */
`timescale 1ns/1ps

module ctrl_regs
    import cmd_pkg::*;
    import dac_pkg::*;
(
    input  logic        CLK100MHZ,
    input  logic        reset,
    input  logic        ldac_len_we,
    input  logic        pattern_we,
    input  payload_u    reg_payload,
    output ldac_len_t   ldac_len,
    output logic [31:0] pattern
);

    // LDAC length, low byte of the DAC word field
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            ldac_len <= LDAC_DEFAULT_LEN;
        end else if (ldac_len_we) begin
            ldac_len <= reg_payload.dac.dac_word[7:0];
        end
    end

    // Output pattern
    // Masked bits take new data, the rest hold
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            pattern <= '0;
        end else if (pattern_we) begin
            pattern <= (pattern & ~reg_payload.pat.mask)
                     | (reg_payload.pat.mask & reg_payload.pat.data);
        end
    end

endmodule

/* dac_bank.sv */
`timescale 1ns/1ps

module dac_bank
    import dac_pkg::*;
#(
    parameter int NUM_DACS = 8
) (
    input  logic                      CLK100MHZ,
    input  logic                      reset,
    input  logic [NUM_DACS-1:0]       dac_start,
    input  logic [DAC_WORD_WIDTH-1:0] dac_word,
    output logic [NUM_DACS-1:0]       dac_busy,
    output logic [NUM_DACS-1:0]       dac_cs_bar,
    output logic [NUM_DACS-1:0]       dac_sclk,
    output logic [NUM_DACS-1:0]       dac_sdi
);

    logic                      tick;
    logic [NUM_DACS-1:0]       start_q;
    logic [DAC_WORD_WIDTH-1:0] word_q;

    // Divide by two, keeps all channels on the same sclk phase
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;
        end
    end

    // Start mask registered, word captured with it
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            start_q <= '0;
        end else begin
            start_q <= dac_start;
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (dac_start != '0) begin
            word_q <= dac_word;
        end
    end

    ////////////////////
    // Channel array
    ////////////////////
    for (genvar i = 0; i < NUM_DACS; i++) begin : g_chan
        dac_serial serial_i (
            .CLK100MHZ (CLK100MHZ),
            .reset     (reset),
            .tick      (tick),
            .start     (start_q[i]),
            .word      (word_q),
            .busy      (dac_busy[i]),
            .cs_bar    (dac_cs_bar[i]),
            .sclk      (dac_sclk[i]),
            .sdi       (dac_sdi[i])
        );
    end

endmodule

/* dac_ctrl_top.sv */
`timescale 1ns/1ps

module dac_ctrl_top
    import cmd_pkg::*;
    import dac_pkg::*;
#(
    parameter int NUM_DACS = 8
) (
    input  logic                CLK100MHZ,
    input  logic                reset,
    input  logic                cmd_valid,
    input  cmd_op_t             cmd_op,
    input  payload_u            cmd_payload,
    input  logic [7:0]          cmd_len,
    output logic                reply_valid,
    output logic [31:0]         reply_data,
    output logic [2:0]          reply_len,
    output logic [NUM_DACS-1:0] dac_cs_bar,
    output logic [NUM_DACS-1:0] dac_sclk,
    output logic [NUM_DACS-1:0] dac_sdi,
    output logic                ldac_bar
);

    // Register file interface
    logic                      ldac_len_we;
    logic                      pattern_we;
    payload_u                  reg_payload;
    ldac_len_t                 ldac_len;
    logic [31:0]               pattern;

    // LDAC handshake
    logic                      ldac_start;
    logic                      ldac_busy;

    // DAC bank handshake
    logic [NUM_DACS-1:0]       dac_start;
    logic [NUM_DACS-1:0]       dac_busy;
    logic [DAC_WORD_WIDTH-1:0] dac_word;

    // Command FSM
    cmd_decoder #(
        .NUM_DACS (NUM_DACS)
    ) decoder_i (
        .CLK100MHZ   (CLK100MHZ),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_payload (cmd_payload),
        .cmd_len     (cmd_len),
        .pattern     (pattern),
        .ldac_busy   (ldac_busy),
        .dac_busy    (dac_busy),
        .reply_valid (reply_valid),
        .reply_data  (reply_data),
        .reply_len   (reply_len),
        .ldac_len_we (ldac_len_we),
        .pattern_we  (pattern_we),
        .reg_payload (reg_payload),
        .ldac_start  (ldac_start),
        .dac_start   (dac_start),
        .dac_word    (dac_word)
    );

    // LDAC length and output pattern
    ctrl_regs regs_i (
        .CLK100MHZ   (CLK100MHZ),
        .reset       (reset),
        .ldac_len_we (ldac_len_we),
        .pattern_we  (pattern_we),
        .reg_payload (reg_payload),
        .ldac_len    (ldac_len),
        .pattern     (pattern)
    );

    // Shared LDAC line
    ldac_pulser ldac_i (
        .CLK100MHZ  (CLK100MHZ),
        .reset      (reset),
        .ldac_start (ldac_start),
        .ldac_len   (ldac_len),
        .ldac_bar   (ldac_bar),
        .ldac_busy  (ldac_busy)
    );

    // Serial links to the DAC chips
    dac_bank #(
        .NUM_DACS (NUM_DACS)
    ) bank_i (
        .CLK100MHZ  (CLK100MHZ),
        .reset      (reset),
        .dac_start  (dac_start),
        .dac_word   (dac_word),
        .dac_busy   (dac_busy),
        .dac_cs_bar (dac_cs_bar),
        .dac_sclk   (dac_sclk),
        .dac_sdi    (dac_sdi)
    );

endmodule

/* dac_pkg.sv */
package dac_pkg;

    ////////////////////
    // DAC frame
    ////////////////////
    // One serial frame per chip select
    localparam int DAC_WORD_WIDTH = 24;

    // Fixed word sent by the load command
    localparam logic [DAC_WORD_WIDTH-1:0] DAC_LD_WORD = 24'h004000;

    ////////////////////
    // LDAC pulse
    ////////////////////
    // Pulse length register type
    typedef logic [7:0] ldac_len_t;

    // Length after reset
    // Low time is this plus two cycles, so 420 ns
    localparam ldac_len_t LDAC_DEFAULT_LEN = 8'd40;

endpackage

/* dac_serial.sv */
`timescale 1ns/1ps

module dac_serial
    import dac_pkg::*;
(
    input  logic                      CLK100MHZ,
    input  logic                      reset,
    input  logic                      tick,
    input  logic                      start,
    input  logic [DAC_WORD_WIDTH-1:0] word,
    output logic                      busy,
    output logic                      cs_bar,
    output logic                      sclk,
    output logic                      sdi
);

    localparam int CNT_WIDTH = $clog2(DAC_WORD_WIDTH);

    logic [DAC_WORD_WIDTH-1:0] shreg;
    logic [CNT_WIDTH-1:0]      bit_cnt;

    ////////////////////
    // Frame sequencer
    ////////////////////
    // Frame begins on a low tick so the first rise lands on the next one
    // Tick high raises sclk, tick low drops it and shifts
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            cs_bar  <= 1'b1;
            sclk    <= 1'b0;
            bit_cnt <= '0;
        end else if (cs_bar) begin
            if (start && !tick) begin
                cs_bar  <= 1'b0;
                bit_cnt <= '0;
            end
        end else if (tick) begin
            // Rising edge, chip samples sdi here
            sclk <= 1'b1;
        end else begin
            sclk <= 1'b0;
            if (bit_cnt == CNT_WIDTH'(DAC_WORD_WIDTH - 1)) begin
                // Last bit sampled, release the chip
                cs_bar <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Shift register, MSB out first
    always_ff @(posedge CLK100MHZ) begin
        if (cs_bar) begin
            shreg <= word;
        end else if (!tick) begin
            shreg <= {shreg[DAC_WORD_WIDTH-2:0], 1'b0};
        end
    end

    assign busy = ~cs_bar;
    // Line parked low between frames
    assign sdi  = busy & shreg[DAC_WORD_WIDTH-1];

    // No clock edges toward a deselected chip
    a_sclk_idle: assert property (@(posedge CLK100MHZ) disable iff (reset)
        cs_bar |-> !sclk);

endmodule

/* ldac_pulser.sv */
`timescale 1ns/1ps

module ldac_pulser
    import dac_pkg::*;
(
    input  logic      CLK100MHZ,
    input  logic      reset,
    input  logic      ldac_start,
    input  ldac_len_t ldac_len,
    output logic      ldac_bar,
    output logic      ldac_busy
);

    // One bit wider so length 255 plus one still fits
    logic [$bits(ldac_len_t):0] count;
    logic                       active;

    // Pulse runs from the cycle after start
    // Count loads len+1 and the line stays low down to zero, len+2 cycles in all
    always_ff @(posedge CLK100MHZ) begin
        if (reset) begin
            active <= 1'b0;
            count  <= '0;
        end else if (ldac_start) begin
            active <= 1'b1;
            count  <= {1'b0, ldac_len} + 1'b1;
        end else if (active) begin
            if (count == '0) begin
                active <= 1'b0;
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Active-low line shared by all chips
    assign ldac_bar  = ~active;
    assign ldac_busy = active;

    // Decoder waits out the pulse before another start
    a_no_restart: assert property (@(posedge CLK100MHZ) disable iff (reset)
        ldac_start |-> !active);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sources.f \
    --top-module tb_dac_ctrl \
    -o sim_tb_dac_ctrl

./obj_dir/sim_tb_dac_ctrl

/* sources.f */
cmd_pkg.sv
dac_pkg.sv
dac_serial.sv
dac_bank.sv
ldac_pulser.sv
ctrl_regs.sv
cmd_decoder.sv
dac_ctrl_top.sv
tb_dac_ctrl.sv

/* tb_dac_ctrl.sv */
`timescale 1ns/1ps

module tb_dac_ctrl
    import cmd_pkg::*;
    import dac_pkg::*;
();

    localparam int NUM_DACS    = 8;
    localparam int NUM_ROUNDS  = 18;
    localparam int NUM_CMDS    = 200;
    localparam int CMD_TIME_NS = 2000;
    localparam int WAIT_LIMIT  = 1000;

    logic                CLK100MHZ;
    logic                reset;
    logic                cmd_valid;
    cmd_op_t             cmd_op;
    payload_u            cmd_payload;
    logic [7:0]          cmd_len;
    logic                reply_valid;
    logic [31:0]         reply_data;
    logic [2:0]          reply_len;
    logic [NUM_DACS-1:0] dac_cs_bar;
    logic [NUM_DACS-1:0] dac_sclk;
    logic [NUM_DACS-1:0] dac_sdi;
    logic                ldac_bar;

    // Reference model state
    integer              seed;
    logic [31:0]         model_pattern;
    ldac_len_t           model_ldac_len;
    integer              round;

    dac_ctrl_top #(
        .NUM_DACS (NUM_DACS)
    ) dut_i (
        .CLK100MHZ   (CLK100MHZ),
        .reset       (reset),
        .cmd_valid   (cmd_valid),
        .cmd_op      (cmd_op),
        .cmd_payload (cmd_payload),
        .cmd_len     (cmd_len),
        .reply_valid (reply_valid),
        .reply_data  (reply_data),
        .reply_len   (reply_len),
        .dac_cs_bar  (dac_cs_bar),
        .dac_sclk    (dac_sclk),
        .dac_sdi     (dac_sdi),
        .ldac_bar    (ldac_bar)
    );

    // 100 MHz clock
    initial begin
        CLK100MHZ = 1'b0;
        forever #5 CLK100MHZ = ~CLK100MHZ;
    end

    // Budget of 2 us per command
    initial begin
        #(NUM_CMDS * CMD_TIME_NS);
        $display("Watchdog expired before all commands finished");
        $display("Test FAILED");
        $fatal(1, "watchdog timeout");
    end

    ////////////////////
    // Helpers
    ////////////////////
    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected 0x%0h actual 0x%0h", test_name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "run aborted");
    endtask

    function automatic logic [7:0] random_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic payload_u random_payload();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = $random(seed);
        lo = $random(seed);
        return {hi, lo};
    endfunction

    // Opcodes the controller decodes
    function automatic logic is_known_op(input logic [7:0] op);
        return (op == OP_WRITE_REG) || (op == OP_LD) || (op == OP_LDAC)
            || (op == OP_LDAC_LENGTH) || (op == OP_UPDATE_BITS) || (op == OP_READ_BITS);
    endfunction

    // Called on a falling edge, returns on the next one (cycle N+1)
    task automatic issue_cmd(input logic [7:0] op, input payload_u payload,
                             input logic [7:0] len);
        cmd_valid   = 1'b1;
        cmd_op      = cmd_op_t'(op);
        cmd_payload = payload;
        cmd_len     = len;
        @(negedge CLK100MHZ);
        cmd_valid   = 1'b0;
    endtask

    // All outputs quiet, then four more cycles
    task automatic wait_idle();
        integer cyc;
        cyc = 0;
        while (reply_valid || !ldac_bar || (dac_cs_bar != '1) || (dac_sclk != '0)) begin
            @(negedge CLK100MHZ);
            cyc = cyc + 1;
            if (cyc > WAIT_LIMIT) abort_run("Outputs did not return to idle");
        end
        repeat (4) @(negedge CLK100MHZ);
    endtask

    task automatic expect_no_reply(input string test_name);
        check_value({test_name, " no reply"}, 64'd0, reply_valid);
    endtask

    // Only the bytes inside reply_len are compared
    task automatic expect_reply(input string test_name, input logic [2:0] len,
                                input logic [31:0] data);
        logic [31:0] keep;
        keep = 32'hFFFF_FFFF << (8 * (4 - len));
        check_value({test_name, " reply valid"}, 64'd1, reply_valid);
        check_value({test_name, " reply length"}, len, reply_len);
        check_value({test_name, " reply data"}, data & keep, reply_data & keep);
        @(negedge CLK100MHZ);
        check_value({test_name, " single strobe"}, 64'd0, reply_valid);
    endtask

    // Sample sdi on every rising sclk seen at the falling clock edge
    task automatic check_frame(input string test_name, input logic [NUM_DACS-1:0] mask,
                               input logic [DAC_WORD_WIDTH-1:0] word);
        logic [NUM_DACS-1:0]       started;
        logic [NUM_DACS-1:0]       finished;
        logic [NUM_DACS-1:0]       prev_sclk;
        logic [DAC_WORD_WIDTH-1:0] shifted [NUM_DACS];
        integer                    bits [NUM_DACS];
        integer                    cyc;
        integer                    ch;
        started   = '0;
        finished  = '0;
        prev_sclk = '0;
        cyc       = 0;
        for (ch = 0; ch < NUM_DACS; ch = ch + 1) begin
            shifted[ch] = '0;
            bits[ch]    = 0;
        end
        while (finished != mask) begin
            @(negedge CLK100MHZ);
            cyc = cyc + 1;
            if (cyc > WAIT_LIMIT) abort_run("DAC frame did not complete");
            for (ch = 0; ch < NUM_DACS; ch = ch + 1) begin
                if (!mask[ch]) begin
                    check_value($sformatf("%s ch%0d idle cs_bar", test_name, ch),
                                64'd1, dac_cs_bar[ch]);
                end else if (!dac_cs_bar[ch]) begin
                    started[ch] = 1'b1;
                    // MSB arrives first, so shift in from the right
                    if (dac_sclk[ch] && !prev_sclk[ch]) begin
                        shifted[ch] = {shifted[ch][DAC_WORD_WIDTH-2:0], dac_sdi[ch]};
                        bits[ch]    = bits[ch] + 1;
                    end
                end else if (started[ch] && !finished[ch]) begin
                    finished[ch] = 1'b1;
                    check_value($sformatf("%s ch%0d bit count", test_name, ch),
                                DAC_WORD_WIDTH, bits[ch]);
                    check_value($sformatf("%s ch%0d word", test_name, ch),
                                word, shifted[ch]);
                end
            end
            prev_sclk = dac_sclk;
        end
    endtask

    // High in N+1, low from N+2 for len+2 cycles
    task automatic check_ldac(input string test_name, input ldac_len_t len);
        integer low_cycles;
        low_cycles = 0;
        check_value({test_name, " high before pulse"}, 64'd1, ldac_bar);
        @(negedge CLK100MHZ);
        check_value({test_name, " pulse start"}, 64'd0, ldac_bar);
        while (!ldac_bar) begin
            low_cycles = low_cycles + 1;
            if (low_cycles > WAIT_LIMIT) abort_run("LDAC pulse never ended");
            @(negedge CLK100MHZ);
        end
        check_value({test_name, " low cycles"}, len + 2, low_cycles);
    endtask

    ////////////////////
    // Behaviors
    ////////////////////
    task automatic test_dac_write(input logic load);
        payload_u   payload;
        logic [7:0] mask;
        payload = random_payload();
        mask    = random_byte();
        if (mask == 8'h00) mask = 8'h01;
        payload.dac.chan_mask = mask;
        wait_idle();
        if (load) begin
            issue_cmd(OP_LD, payload, random_byte());
            expect_no_reply("load");
            check_frame("load", mask, 24'h004000);
        end else begin
            issue_cmd(OP_WRITE_REG, payload, 8'd4);
            expect_no_reply("write_reg");
            check_frame("write_reg", mask, payload.dac.dac_word);
        end
    endtask

    task automatic test_wrong_len();
        logic [7:0] len;
        len = random_byte();
        if (len == 8'd4) len = len + 8'd1;
        wait_idle();
        issue_cmd(OP_WRITE_REG, random_payload(), len);
        expect_reply("wrong_len", 3'd2, {8'hE1, len, 16'h0000});
    endtask

    task automatic test_ldac();
        payload_u payload;
        payload = random_payload();
        wait_idle();
        issue_cmd(OP_LDAC_LENGTH, payload, 8'd1);
        expect_no_reply("ldac_length");
        // Length sits in the low byte of the DAC word field
        model_ldac_len = payload.dac.dac_word[7:0];
        wait_idle();
        issue_cmd(OP_LDAC, random_payload(), 8'd0);
        expect_no_reply("ldac");
        check_ldac("ldac pulse", model_ldac_len);
    endtask

    task automatic test_pattern();
        payload_u payload;
        integer   b;
        repeat (2) begin
            payload = random_payload();
            wait_idle();
            issue_cmd(OP_UPDATE_BITS, payload, 8'd8);
            expect_no_reply("update_bits");
            for (b = 0; b < 32; b = b + 1) begin
                if (payload.pat.mask[b]) model_pattern[b] = payload.pat.data[b];
            end
            wait_idle();
            issue_cmd(OP_READ_BITS, random_payload(), 8'd0);
            expect_reply("read_bits", 3'd4, model_pattern);
        end
    endtask

    task automatic test_unknown();
        logic [7:0] op;
        op = random_byte();
        while (is_known_op(op)) op = random_byte();
        wait_idle();
        issue_cmd(op, random_payload(), random_byte());
        expect_reply("unknown_op", 3'd1, {8'hEE, 24'h000000});
    endtask

    ////////////////////
    // Main sequence
    ////////////////////
    initial begin
        seed           = 52;
        reset          = 1'b1;
        cmd_valid      = 1'b0;
        cmd_op         = OP_READ_BITS;
        cmd_payload    = '0;
        cmd_len        = 8'd0;
        model_pattern  = '0;
        model_ldac_len = 8'd40;
        repeat (4) @(negedge CLK100MHZ);
        reset = 1'b0;

        // Idle levels straight out of reset
        check_value("reset reply_valid", 64'd0, reply_valid);
        check_value("reset sclk", 64'd0, dac_sclk);
        check_value("reset cs_bar", {NUM_DACS{1'b1}}, dac_cs_bar);
        check_value("reset ldac_bar", 64'd1, ldac_bar);

        // Pattern clear and default pulse length
        issue_cmd(OP_READ_BITS, '0, 8'd0);
        expect_reply("reset pattern", 3'd4, 32'h0000_0000);
        wait_idle();
        issue_cmd(OP_LDAC, '0, 8'd0);
        check_ldac("default ldac", model_ldac_len);

        for (round = 0; round < NUM_ROUNDS; round = round + 1) begin
            test_dac_write(1'b0);
            test_dac_write(1'b1);
            test_wrong_len();
            test_ldac();
            test_pattern();
            test_unknown();
        end

        wait_idle();
        $display("Test OK");
        $finish;
    end

endmodule
